//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = iso14443a_rx_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- hw/iso14443a_pkg.sv
// ----------------------------------------
// iso14443a_pkg
// shared timing constants, sequence codes and
// result records for the 14443A receive path
// ----------------------------------------

package iso14443a_pkg;

    localparam int BIT_TICKS  = 128;                // one etu in picc_clk ticks
    localparam int HALF_TICKS = 64;                 // nominal start of the X pause
    localparam int PAUSE_TOL  = 16;                 // accepted drift of a pause start
    localparam int CNT_W      = $clog2(BIT_TICKS);  // width of the window counter

    // modified miller sequence kinds
    typedef enum logic [2:0] {
        SEQ_SOC,
        SEQ_X,
        SEQ_Y,
        SEQ_Z,
        SEQ_ERR   // pause at a bad offset or two pauses in one window
    } miller_seq_e;

    typedef struct packed {
        logic        valid;
        miller_seq_e kind;
    } seq_evt_t;

    typedef struct packed {
        logic [7:0] data;        // lsb was received first
        logic       parity_err;  // parity bit did not make the count odd
    } rx_byte_t;

    typedef struct packed {
        logic [3:0] last_bits;        // 0 = whole bytes, else bits of the last byte
        logic       seq_err;
        logic       parity_seen_err;  // any byte of the frame failed parity
    } frame_end_t;

    // window decoder states
    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_SOC,   // rest of the soc bit window
        SQ_BITS
    } seq_state_e;

    typedef enum logic {
        FR_IDLE,
        FR_ACTIVE
    } frame_state_e;

endpackage

//--- hw/iso14443a_rx_top.sv
// ----------------------------------------
// iso14443a_rx_top
// picc receive path, pause_n in, bytes and
// frame end reports out
// ----------------------------------------

`timescale 1ns/1ps

module iso14443a_rx_top (
    input  logic                      picc_clk,
    input  logic                      rst_n,
    input  logic                      pause_n,     // async from the pause detector
    output iso14443a_pkg::rx_byte_t   rx_byte,
    output logic                      rx_valid,
    output iso14443a_pkg::frame_end_t frame_end,
    output logic                      frame_done,
    output logic                      busy
);

    import iso14443a_pkg::*;

    logic     pause_start;  // synchronised pause edge
    seq_evt_t seq;          // one event per bit window

    pause_n_sync pause_n_sync_inst (
        .picc_clk    (picc_clk),
        .rst_n       (rst_n),
        .pause_n     (pause_n),
        .pause_start (pause_start)
    );

    miller_seq_decode miller_seq_decode_inst (
        .picc_clk    (picc_clk),
        .rst_n       (rst_n),
        .pause_start (pause_start),
        .seq         (seq)
    );

    miller_frame_decode miller_frame_decode_inst (
        .picc_clk   (picc_clk),
        .rst_n      (rst_n),
        .seq        (seq),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .frame_end  (frame_end),
        .frame_done (frame_done),
        .busy       (busy)
    );

endmodule

//--- hw/miller_frame_decode.sv
// ----------------------------------------
// miller_frame_decode
// turns miller sequences into bits, frames them
// into bytes with odd parity and reports the
// end of every frame, short frames included
// ----------------------------------------

`timescale 1ns/1ps

module miller_frame_decode (
    input  logic                      picc_clk,
    input  logic                      rst_n,
    input  iso14443a_pkg::seq_evt_t   seq,
    output iso14443a_pkg::rx_byte_t   rx_byte,
    output logic                      rx_valid,
    output iso14443a_pkg::frame_end_t frame_end,
    output logic                      frame_done,
    output logic                      busy
);

    import iso14443a_pkg::*;

    frame_state_e state;
    logic         prev_bit;      // last decoded bit, soc counts as 0
    logic [7:0]   data_q;        // byte being assembled, lsb first
    logic [3:0]   bit_cnt;       // 0..7 data, 8 means parity is next
    logic         par_acc;       // xor of the data bits so far
    logic         par_err_seen;  // sticky over the frame

    logic         soc;
    logic         bit_valid;
    logic         bit_val;
    logic         eoc;       // logic 0 then Y
    logic         code_err;
    logic         par_bad;
    logic [3:0]   tail_bits;     // bits of the unfinished byte at the frame end

    assign soc     = seq.valid && seq.kind == SEQ_SOC;
    // odd parity means data plus parity bit holds an odd number of ones
    assign par_bad = ~(par_acc ^ bit_val);
    // the logic 0 of an eoc was shifted in but carries no data
    assign tail_bits = eoc ? bit_cnt - 4'd1 : bit_cnt;

    always_comb begin
        bit_valid = 1'b0;
        bit_val   = 1'b0;
        eoc       = 1'b0;
        code_err  = 1'b0;
        if (seq.valid && state == FR_ACTIVE) begin
            case (seq.kind)
                SEQ_X: begin
                    bit_valid = 1'b1;
                    bit_val   = 1'b1;
                end
                SEQ_Z: begin
                    if (prev_bit)
                        code_err = 1'b1;  // a 0 after a 1 must be Y
                    else
                        bit_valid = 1'b1;
                end
                SEQ_Y: begin
                    if (prev_bit)
                        bit_valid = 1'b1;  // the 0 that follows a 1
                    else
                        eoc = 1'b1;
                end
                default: code_err = 1'b1;  // SEQ_ERR or a soc mid frame
            endcase
        end
    end

    always_ff @(posedge picc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= FR_IDLE;
            rx_valid     <= 1'b0;
            frame_done   <= 1'b0;
            prev_bit     <= 1'b0;
            bit_cnt      <= '0;
            par_acc      <= 1'b0;
            par_err_seen <= 1'b0;
        end else begin
            rx_valid   <= 1'b0;
            frame_done <= 1'b0;
            if (state == FR_IDLE) begin
                if (soc) begin
                    state        <= FR_ACTIVE;
                    prev_bit     <= 1'b0;
                    bit_cnt      <= '0;
                    par_acc      <= 1'b0;
                    par_err_seen <= 1'b0;
                end
            end else if (bit_valid) begin
                prev_bit <= bit_val;
                if (bit_cnt == 4'd8) begin  // parity bit closes the byte
                    rx_valid     <= 1'b1;
                    par_err_seen <= par_err_seen | par_bad;
                    bit_cnt      <= '0;
                    par_acc      <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    par_acc <= par_acc ^ bit_val;
                end
            end else if (eoc || code_err) begin
                state      <= FR_IDLE;
                frame_done <= 1'b1;
            end
        end
    end

    // payload path
    always_ff @(posedge picc_clk) begin
        if (state == FR_IDLE && soc)
            data_q <= '0;
        if (bit_valid) begin
            if (bit_cnt == 4'd8) begin
                rx_byte.data       <= data_q;
                rx_byte.parity_err <= par_bad;
                data_q             <= '0;  // upper bits of a short tail stay 0
            end else begin
                data_q[bit_cnt[2:0]] <= bit_val;
            end
        end
        if (eoc || code_err) begin
            frame_end.last_bits       <= tail_bits;
            frame_end.seq_err         <= code_err;
            frame_end.parity_seen_err <= par_err_seen;
            if (tail_bits != 4'd0) begin  // partial byte shows up with frame_done
                rx_byte.data       <= data_q;
                rx_byte.parity_err <= 1'b0;
            end
        end
    end

    // stays high through the frame_done cycle
    assign busy = (state == FR_ACTIVE) | frame_done;

endmodule

//--- hw/miller_seq_decode.sv
// ----------------------------------------
// miller_seq_decode
// places pause starts on the etu grid and
// classifies every bit window as X, Y or Z
// ----------------------------------------

`timescale 1ns/1ps

module miller_seq_decode (
    input  logic                    picc_clk,
    input  logic                    rst_n,
    input  logic                    pause_start,
    output iso14443a_pkg::seq_evt_t seq
);

    import iso14443a_pkg::*;

    seq_state_e       state;
    logic [CNT_W-1:0] tick_cnt;     // tick within the current window
    logic [CNT_W-1:0] pause_off;    // offset of the first pause in the window
    logic             pause_seen;
    logic             pause_multi;  // more than one pause in the window
    logic             prev_y;       // last window was a Y

    logic             win_end;
    logic             seen_now;
    logic             multi_now;
    logic [CNT_W-1:0] off_now;
    miller_seq_e      kind_now;

    assign win_end   = (tick_cnt == CNT_W'(BIT_TICKS - 1));
    // a pause on the last tick still counts for this window
    assign seen_now  = pause_seen | pause_start;
    assign multi_now = pause_multi | (pause_seen & pause_start);
    assign off_now   = pause_seen ? pause_off : tick_cnt;

    always_comb begin
        if (!seen_now) begin
            kind_now = SEQ_Y;  // no pause at all
        end else if (multi_now) begin
            kind_now = SEQ_ERR;
        end else if (off_now < CNT_W'(PAUSE_TOL)) begin
            kind_now = SEQ_Z;  // pause at the window start
        end else if (off_now >= CNT_W'(HALF_TICKS - PAUSE_TOL) &&
                     off_now <= CNT_W'(HALF_TICKS + PAUSE_TOL)) begin
            kind_now = SEQ_X;  // mid bit pause
        end else begin
            kind_now = SEQ_ERR;
        end
    end

    always_ff @(posedge picc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SQ_IDLE;
            tick_cnt    <= '0;
            pause_off   <= '0;
            pause_seen  <= 1'b0;
            pause_multi <= 1'b0;
            prev_y      <= 1'b0;
            seq         <= '0;
        end else begin
            seq.valid <= 1'b0;  // events last a single cycle
            case (state)
                SQ_IDLE: begin
                    tick_cnt    <= '0;
                    pause_seen  <= 1'b0;
                    pause_multi <= 1'b0;
                    prev_y      <= 1'b0;
                    if (pause_start) begin  // soc pause is tick 0 of the grid
                        state     <= SQ_SOC;
                        tick_cnt  <= CNT_W'(1);
                        seq.valid <= 1'b1;
                        seq.kind  <= SEQ_SOC;
                    end
                end
                default: begin
                    tick_cnt <= win_end ? '0 : tick_cnt + 1'b1;
                    if (win_end) begin
                        pause_seen  <= 1'b0;
                        pause_multi <= 1'b0;
                    end else if (pause_start) begin
                        pause_seen  <= 1'b1;
                        pause_multi <= pause_multi | pause_seen;
                        if (!pause_seen)
                            pause_off <= tick_cnt;
                    end
                    if (win_end && state == SQ_SOC) begin
                        // soc window already reported, only a stray pause matters
                        if (seen_now) begin
                            seq.valid <= 1'b1;
                            seq.kind  <= SEQ_ERR;
                            state     <= SQ_IDLE;
                        end else begin
                            state <= SQ_BITS;
                        end
                    end else if (win_end) begin
                        seq.valid <= 1'b1;
                        seq.kind  <= kind_now;
                        prev_y    <= (kind_now == SEQ_Y);
                        // Y Y never occurs inside a frame
                        if (kind_now == SEQ_ERR || (prev_y && kind_now == SEQ_Y))
                            state <= SQ_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/pause_n_sync.sv
// ----------------------------------------
// pause_n_sync
// brings the asynchronous pause_n into the
// picc_clk domain and pulses on each pause start
// ----------------------------------------

`timescale 1ns/1ps

module pause_n_sync (
    input  logic picc_clk,
    input  logic rst_n,
    input  logic pause_n,      // async, low during a pause
    output logic pause_start   // one cycle per falling edge
);

    logic [1:0] sync_q;  // two flop synchroniser, sync_q[1] is the safe copy
    logic       prev_q;  // previous synchronised level

    always_ff @(posedge picc_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q      <= 2'b11;  // no pause level
            prev_q      <= 1'b1;
            pause_start <= 1'b0;
        end else begin
            sync_q      <= {sync_q[0], pause_n};
            prev_q      <= sync_q[1];
            // high to low on the synchronised line
            pause_start <= prev_q & ~sync_q[1];
        end
    end

    // latency from pause_n is fixed per edge, so the etu grid stays intact

endmodule

//--- tests/iso14443a_rx_assert.sv
// ----------------------------------------
// iso14443a_rx_assert
// strobe and pause edge rules of the receive
// path, bound into the top level
// ----------------------------------------

`timescale 1ns/1ps

module iso14443a_rx_assert (
    input logic picc_clk,
    input logic rst_n,
    input logic pause_start,  // internal edge pulse of the top level
    input logic rx_valid,
    input logic frame_done,
    input logic busy
);

    // a byte strobe and a frame end never share a cycle
    a_strobe_excl: assert property (@(posedge picc_clk) disable iff (!rst_n)
        !(rx_valid && frame_done))
        else $error("rx_valid and frame_done high in the same cycle");

    // strobes belong to a frame in progress
    a_strobe_busy: assert property (@(posedge picc_clk) disable iff (!rst_n)
        (rx_valid || frame_done) |-> busy)
        else $error("strobe seen while busy is low");

    a_edge_single: assert property (@(posedge picc_clk) disable iff (!rst_n)
        pause_start |=> !pause_start)  // one pulse per falling edge
        else $error("pause_start high on two cycles in a row");

endmodule

bind iso14443a_rx_top iso14443a_rx_assert rx_assert (
    .picc_clk    (picc_clk),
    .rst_n       (rst_n),
    .pause_start (pause_start),
    .rx_valid    (rx_valid),
    .frame_done  (frame_done),
    .busy        (busy)
);

//--- tests/iso14443a_rx_tb.sv
// ----------------------------------------
// iso14443a_rx_tb
// random reader frames sent as modified miller
// pauses, bytes and frame ends checked against
// a bit level model of the coding rules
// ----------------------------------------

`timescale 1ns/1ps

module iso14443a_rx_tb;

    import iso14443a_pkg::*;

    localparam int     CLK_PERIOD  = 8;
    localparam int     NUM_FRAMES  = 40;
    localparam int     PAUSE_LEN   = 32;  // ticks low per pause
    localparam int     BAD_OFFSET  = 32;  // between the Z and X bands
    localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * 40 * BIT_TICKS * CLK_PERIOD * 2;

    logic        picc_clk;
    logic        rst_n;
    logic        pause_n;
    rx_byte_t    rx_byte;
    logic        rx_valid;
    frame_end_t  frame_end;
    logic        frame_done;
    logic        busy;

    logic [15:0] lfsr_q;
    logic        frame_bits[$];  // data and parity bits in line order
    rx_byte_t    exp_bytes[$];
    rx_byte_t    exp_tails[$];   // partial byte shown with frame_done
    frame_end_t  exp_ends[$];
    int          done_cnt  = 0;
    int          n_short   = 0;
    int          n_bad_par = 0;
    int          n_seq_err = 0;

    iso14443a_rx_top dut (
        .picc_clk   (picc_clk),
        .rst_n      (rst_n),
        .pause_n    (pause_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .frame_end  (frame_end),
        .frame_done (frame_done),
        .busy       (busy)
    );

    initial begin
        picc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) picc_clk = ~picc_clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all frames were decoded");
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);  // one step per bit
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    task automatic check_byte(input rx_byte_t got, input rx_byte_t exp);
        if (got !== exp) begin
            $display("[FAIL] rx_byte got 0x%h expected 0x%h", got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_frame_end(input frame_end_t got, input frame_end_t exp);
        if (got !== exp) begin
            $display("[FAIL] frame_end got 0x%h expected 0x%h", got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // expected strobes, err_at < 0 means a clean frame
    task automatic model_frame(input int err_at);
        logic [7:0] acc;
        logic [3:0] cnt;
        logic       sticky;
        logic       bit_v;
        int         n;
        rx_byte_t   b;
        frame_end_t fe;
        acc    = '0;
        cnt    = '0;
        sticky = 1'b0;
        // the logic 0 of the end of communication carries no data
        n = (err_at >= 0) ? err_at : frame_bits.size();
        for (int i = 0; i < n; i++) begin
            bit_v = frame_bits[i];
            if (cnt == 4'd8) begin  // ninth bit is the parity bit
                b.data       = acc;
                b.parity_err = (($countones({acc, bit_v}) % 2) == 0);  // ones must come out odd
                exp_bytes.push_back(b);
                sticky = sticky | b.parity_err;
                acc    = '0;
                cnt    = '0;
            end else begin
                acc[cnt[2:0]] = bit_v;  // lsb first
                cnt           = cnt + 4'd1;
            end
        end
        fe.last_bits       = cnt;
        fe.seq_err         = (err_at >= 0);
        fe.parity_seen_err = sticky;
        b.data             = acc;
        b.parity_err       = 1'b0;
        exp_ends.push_back(fe);
        exp_tails.push_back(b);
    endtask

    // one bit window, pause_at < 0 gives no pause
    task automatic send_window(input int pause_at);
        for (int t = 0; t < BIT_TICKS; t++) begin
            @(posedge picc_clk);
            pause_n <= !(pause_at >= 0 && t >= pause_at && t < pause_at + PAUSE_LEN);
        end
    endtask

    task automatic send_frame(input int err_at);
        logic prev;
        prev = 1'b0;       // soc counts as a 0
        send_window(0);    // soc
        for (int i = 0; i < frame_bits.size(); i++) begin
            if (i == err_at) begin
                send_window(BAD_OFFSET);  // frame is dropped from here on
                return;
            end
            if (frame_bits[i])
                send_window(HALF_TICKS);  // X
            else if (prev)
                send_window(-1);          // Y
            else
                send_window(0);           // Z
            prev = frame_bits[i];
        end
        send_window(prev ? -1 : 0);  // eoc, logic 0
        send_window(-1);             // then Y
    endtask

    task automatic wait_frame_done(input int count);
        int waited;
        waited = 0;
        while (done_cnt < count) begin
            @(posedge picc_clk);
            waited++;
            if (waited > 4 * BIT_TICKS)
                abort_run("frame_done did not arrive after the end of a frame");
        end
    endtask

    task automatic check_idle(input string where);
        @(negedge picc_clk);
        if (busy !== 1'b0)
            abort_run($sformatf("busy is still high %s", where));
    endtask

    // outputs sampled away from the driving edge
    always @(negedge picc_clk) begin
        frame_end_t fe_exp;
        rx_byte_t   tail_exp;
        if (rst_n) begin
            if (rx_valid) begin
                if (exp_bytes.size() == 0)
                    abort_run("rx_valid pulsed with no byte expected");
                else
                    check_byte(rx_byte, exp_bytes.pop_front());
            end
            if (frame_done) begin
                if (exp_ends.size() == 0) begin
                    abort_run("frame_done pulsed with no frame expected");
                end else if (exp_bytes.size() != 0) begin
                    abort_run("frame ended with bytes still missing");
                end else begin
                    fe_exp   = exp_ends.pop_front();
                    tail_exp = exp_tails.pop_front();
                    check_frame_end(frame_end, fe_exp);
                    if (fe_exp.last_bits != 4'd0)
                        check_byte(rx_byte, tail_exp);  // unfinished byte not lost
                    done_cnt++;
                end
            end
        end
    end

    initial begin
        int         nbytes;
        int         err_at;
        logic [7:0] byte_v;
        logic       par_bit;
        logic       even;
        lfsr_q  = 16'd57;
        pause_n = 1'b1;
        rst_n   = 1'b0;
        repeat (10) @(posedge picc_clk);
        rst_n <= 1'b1;
        repeat (2 * BIT_TICKS) @(posedge picc_clk);
        check_idle("after reset");
        for (int f = 0; f < NUM_FRAMES; f++) begin
            frame_bits.delete();
            if (take_bits(2) == 0) begin  // reqa style short frame
                n_short++;
                for (int i = 0; i < 7; i++)
                    frame_bits.push_back(1'(take_bits(1)));
            end else begin
                nbytes = take_bits(2) + 1;
                for (int b = 0; b < nbytes; b++) begin
                    byte_v  = 8'(take_bits(8));
                    even    = (take_bits(3) == 0);
                    par_bit = even ? ^byte_v : ~^byte_v;
                    if (even)
                        n_bad_par++;
                    for (int i = 0; i < 8; i++) begin
                        frame_bits.push_back(byte_v[0]);
                        byte_v = byte_v >> 1;
                    end
                    frame_bits.push_back(par_bit);
                end
            end
            err_at = -1;
            if (take_bits(3) == 0) begin  // pause at an illegal offset
                err_at = take_bits(6) % frame_bits.size();
                n_seq_err++;
            end
            model_frame(err_at);
            send_frame(err_at);
            wait_frame_done(f + 1);
            repeat (2 * BIT_TICKS) @(posedge picc_clk);
            check_idle("between frames");
        end
        if (exp_bytes.size() != 0 || exp_ends.size() != 0) begin
            abort_run("expected strobes never arrived");
        end else begin
            $display("%0d frames, %0d short, %0d even parity bytes, %0d illegal pauses",
                     NUM_FRAMES, n_short, n_bad_par, n_seq_err);
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
hw/iso14443a_pkg.sv
hw/pause_n_sync.sv
hw/miller_seq_decode.sv
hw/miller_frame_decode.sv
hw/iso14443a_rx_top.sv
tests/iso14443a_rx_assert.sv
tests/iso14443a_rx_tb.sv
